//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Reset vector, low byte first
`define CPU_RESET_VEC_LO 16'hFFFC
`define CPU_RESET_VEC_HI 16'hFFFD

// High address byte for zero page accesses
`define CPU_ZERO_PAGE_HI 8'h00

`endif

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Supported opcodes, 6502 encodings
  typedef enum logic [7:0] {
    OP_NOP     = 8'hEA,
    OP_TAX     = 8'hAA,
    OP_LDA_IMM = 8'hA9,
    OP_LDA_ZP  = 8'hA5,
    OP_LDA_ZPX = 8'hB5,
    OP_LDA_ABS = 8'hAD,
    OP_LDX_IMM = 8'hA2,
    OP_LDX_ZP  = 8'hA6,
    OP_ADC_IMM = 8'h69,
    OP_STA_ZP  = 8'h85,
    OP_JMP_ABS = 8'h4C
  } opcode_e;

  // Sequencer stages, 4 and 5 unused
  typedef enum logic [2:0] {
    STAGE_FETCH    = 3'd0,
    STAGE_OPERAND  = 3'd1,
    STAGE_ADDR     = 3'd2,
    STAGE_FINAL    = 3'd3,
    STAGE_RESET_LO = 3'd6,
    STAGE_RESET_HI = 3'd7
  } stage_e;

  typedef enum logic [2:0] {
    STATUS_CARRY    = 3'd0,
    STATUS_ZERO     = 3'd1,
    STATUS_NEGATIVE = 3'd7
  } status_bit_e;

  typedef logic [7:0] status_t;

endpackage

`default_nettype wire

//--- cpu_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;

  // Register loads
  logic load_acc_from_data;
  logic load_acc_from_hold;
  logic load_x_from_data;
  logic load_x_from_acc;
  logic data_flags_to_status;
  logic alu_flags_to_status;

  // ALU and hold register
  logic alu_add_acc;
  logic alu_add_x;
  logic data_to_hold;

  // Address register sources
  logic addr_from_data_zp;
  logic addr_from_hold_zp;
  logic addr_high_from_data;
  logic addr_from_pc_next;
  logic addr_from_vector_hi;

  // Program counter
  logic pc_increment;
  logic pc_low_from_data;
  logic pc_high_from_data;

  logic acc_to_write_data;

  modport decode (
    output load_acc_from_data, load_acc_from_hold, load_x_from_data, load_x_from_acc,
    output data_flags_to_status, alu_flags_to_status,
    output alu_add_acc, alu_add_x, data_to_hold,
    output addr_from_data_zp, addr_from_hold_zp, addr_high_from_data,
    output addr_from_pc_next, addr_from_vector_hi,
    output pc_increment, pc_low_from_data, pc_high_from_data,
    output acc_to_write_data
  );

  modport alu (
    input alu_add_acc, alu_add_x, data_to_hold
  );

  modport datapath (
    input load_acc_from_data, load_acc_from_hold, load_x_from_data, load_x_from_acc,
    input data_flags_to_status, alu_flags_to_status,
    input addr_from_data_zp, addr_from_hold_zp, addr_high_from_data,
    input addr_from_pc_next, addr_from_vector_hi,
    input pc_increment, pc_low_from_data, pc_high_from_data,
    input acc_to_write_data
  );

endinterface

`default_nettype wire

//--- cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_decode
  import cpu_pkg::*;
(
  input  logic                   clock_i,
  input  logic                   reset_i,
  input  logic [`CPU_DATA_W-1:0] data_i,
  input  logic                   data_valid_i,
  cpu_ctrl_if.decode             ctrl,
  output logic                   bus_read_o,
  output logic                   bus_write_o
);

  stage_e  stage;
  stage_e  stage_next;
  opcode_e opcode;
  opcode_e opcode_next;
  logic    bus_read;
  logic    bus_write;
  logic    need_byte;
  logic    finish;

  always_comb begin
    ctrl.load_acc_from_data   = 1'b0;
    ctrl.load_acc_from_hold   = 1'b0;
    ctrl.load_x_from_data     = 1'b0;
    ctrl.load_x_from_acc      = 1'b0;
    ctrl.data_flags_to_status = 1'b0;
    ctrl.alu_flags_to_status  = 1'b0;
    ctrl.alu_add_acc          = 1'b0;
    ctrl.alu_add_x            = 1'b0;
    ctrl.data_to_hold         = 1'b0;
    ctrl.addr_from_data_zp    = 1'b0;
    ctrl.addr_from_hold_zp    = 1'b0;
    ctrl.addr_high_from_data  = 1'b0;
    ctrl.addr_from_pc_next    = 1'b0;
    ctrl.addr_from_vector_hi  = 1'b0;
    ctrl.pc_increment         = 1'b0;
    ctrl.pc_low_from_data     = 1'b0;
    ctrl.pc_high_from_data    = 1'b0;
    ctrl.acc_to_write_data    = 1'b0;
    bus_read    = 1'b0;
    bus_write   = 1'b0;
    need_byte   = 1'b1;
    finish      = 1'b0;
    stage_next  = stage;
    opcode_next = opcode;

    case (stage)
      STAGE_RESET_LO: begin
        if (data_valid_i) begin
          // Low vector byte goes to both PC and hold
          ctrl.pc_low_from_data    = 1'b1;
          ctrl.data_to_hold        = 1'b1;
          ctrl.addr_from_vector_hi = 1'b1;
          bus_read   = 1'b1;
          stage_next = STAGE_RESET_HI;
        end
      end

      STAGE_RESET_HI: begin
        if (data_valid_i) begin
          ctrl.pc_high_from_data   = 1'b1;
          ctrl.addr_from_hold_zp   = 1'b1;
          ctrl.addr_high_from_data = 1'b1;
          bus_read   = 1'b1;
          stage_next = STAGE_FETCH;
        end
      end

      STAGE_FETCH: begin
        // Sum from a preceding ADC is committed here
        ctrl.load_acc_from_hold = (opcode == OP_ADC_IMM);
        if (data_valid_i) begin
          opcode_next = opcode_e'(data_i);
          stage_next  = STAGE_OPERAND;
          if (data_i != OP_NOP && data_i != OP_TAX) begin
            ctrl.pc_increment      = 1'b1;
            ctrl.addr_from_pc_next = 1'b1;
            bus_read = 1'b1;
          end
        end
      end

      STAGE_OPERAND: begin
        case (opcode)
          OP_LDA_IMM, OP_LDX_IMM: begin
            if (data_valid_i) begin
              ctrl.load_acc_from_data   = (opcode == OP_LDA_IMM);
              ctrl.load_x_from_data     = (opcode == OP_LDX_IMM);
              ctrl.data_flags_to_status = 1'b1;
              finish = 1'b1;
            end
          end
          OP_ADC_IMM: begin
            if (data_valid_i) begin
              ctrl.alu_add_acc         = 1'b1;
              ctrl.alu_flags_to_status = 1'b1;
              finish = 1'b1;
            end
          end
          OP_LDA_ZP, OP_LDX_ZP: begin
            if (data_valid_i) begin
              ctrl.addr_from_data_zp = 1'b1;
              bus_read   = 1'b1;
              stage_next = STAGE_FINAL;
            end
          end
          OP_STA_ZP: begin
            if (data_valid_i) begin
              ctrl.addr_from_data_zp = 1'b1;
              ctrl.acc_to_write_data = 1'b1;
              bus_write  = 1'b1;
              stage_next = STAGE_FINAL;
            end
          end
          OP_LDA_ZPX: begin
            if (data_valid_i) begin
              ctrl.alu_add_x = 1'b1;
              stage_next = STAGE_ADDR;
            end
          end
          OP_LDA_ABS, OP_JMP_ABS: begin
            if (data_valid_i) begin
              // JMP also takes the target low byte into PC now
              ctrl.pc_low_from_data  = (opcode == OP_JMP_ABS);
              ctrl.data_to_hold      = 1'b1;
              ctrl.addr_from_pc_next = 1'b1;
              bus_read   = 1'b1;
              stage_next = STAGE_ADDR;
            end
          end
          OP_TAX: begin
            need_byte = 1'b0;
            ctrl.load_x_from_acc = 1'b1;
            finish = 1'b1;
          end
          // NOP, and anything unknown is skipped like one
          default: begin
            need_byte = 1'b0;
            finish = 1'b1;
          end
        endcase
      end

      STAGE_ADDR: begin
        case (opcode)
          OP_LDA_ZPX: begin
            need_byte = 1'b0;
            ctrl.addr_from_hold_zp = 1'b1;
            bus_read   = 1'b1;
            stage_next = STAGE_FINAL;
          end
          OP_LDA_ABS, OP_JMP_ABS: begin
            if (data_valid_i) begin
              ctrl.addr_from_hold_zp   = 1'b1;
              ctrl.addr_high_from_data = 1'b1;
              ctrl.pc_increment        = (opcode == OP_LDA_ABS);
              ctrl.pc_high_from_data   = (opcode == OP_JMP_ABS);
              bus_read   = 1'b1;
              stage_next = (opcode == OP_JMP_ABS) ? STAGE_FETCH : STAGE_FINAL;
            end
          end
          default: begin
            need_byte = 1'b0;
            finish = 1'b1;
          end
        endcase
      end

      STAGE_FINAL: begin
        case (opcode)
          OP_LDA_ZP, OP_LDA_ZPX, OP_LDA_ABS, OP_LDX_ZP: begin
            if (data_valid_i) begin
              ctrl.load_acc_from_data   = (opcode != OP_LDX_ZP);
              ctrl.load_x_from_data     = (opcode == OP_LDX_ZP);
              ctrl.data_flags_to_status = 1'b1;
              finish = 1'b1;
            end
          end
          // STA write cycle, nothing to wait for
          default: begin
            need_byte = 1'b0;
            finish = 1'b1;
          end
        endcase
      end

      default: begin
        stage_next = STAGE_FETCH;
      end
    endcase

    // Step to the next opcode
    if (finish) begin
      ctrl.pc_increment      = 1'b1;
      ctrl.addr_from_pc_next = 1'b1;
      bus_read   = 1'b1;
      stage_next = STAGE_FETCH;
    end

    // Keep requesting while the byte is outstanding
    if (need_byte && !data_valid_i) begin
      bus_read = 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage       <= STAGE_RESET_LO;
      opcode      <= OP_NOP;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else begin
      stage       <= stage_next;
      opcode      <= opcode_next;
      bus_read_o  <= bus_read;
      bus_write_o <= bus_write;
    end
  end

  a_bus_exclusive: assert property (
    @(posedge clock_i) disable iff (reset_i) !(bus_read_o && bus_write_o)
  );

  a_stage_legal: assert property (
    @(posedge clock_i) disable iff (reset_i)
      stage inside {STAGE_FETCH, STAGE_OPERAND, STAGE_ADDR, STAGE_FINAL,
                    STAGE_RESET_LO, STAGE_RESET_HI}
  );

endmodule

`default_nettype wire

//--- cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_alu
  import cpu_pkg::*;
(
  input  logic                   clock_i,
  input  logic                   reset_i,
  cpu_ctrl_if.alu                ctrl,
  input  logic [`CPU_DATA_W-1:0] data_i,
  input  logic [`CPU_DATA_W-1:0] acc_i,
  input  logic [`CPU_DATA_W-1:0] x_i,
  input  logic                   carry_i,
  output logic [`CPU_DATA_W-1:0] hold_o,
  output status_t                flags_o
);

  logic [`CPU_DATA_W-1:0] operand_a;
  logic [`CPU_DATA_W-1:0] sum;
  logic                   carry_in;
  logic                   carry_out;

  always_comb begin
    operand_a = '0;
    if (ctrl.alu_add_acc) begin
      operand_a = acc_i;
    end
    if (ctrl.alu_add_x) begin
      operand_a = x_i;
    end
    // Index adds ignore carry and wrap in page zero
    carry_in = ctrl.alu_add_acc & carry_i;
    {carry_out, sum} = {1'b0, operand_a} + {1'b0, data_i} + {{`CPU_DATA_W{1'b0}}, carry_in};
  end

  always_comb begin
    flags_o                  = '0;
    flags_o[STATUS_CARRY]    = carry_out;
    flags_o[STATUS_ZERO]     = (sum == '0);
    flags_o[STATUS_NEGATIVE] = sum[`CPU_DATA_W-1];
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      hold_o <= '0;
    end else if (ctrl.alu_add_acc || ctrl.alu_add_x) begin
      hold_o <= sum;
    end else if (ctrl.data_to_hold) begin
      hold_o <= data_i;
    end
  end

  a_one_operand: assert property (
    @(posedge clock_i) disable iff (reset_i) !(ctrl.alu_add_acc && ctrl.alu_add_x)
  );

endmodule

`default_nettype wire

//--- cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_datapath
  import cpu_pkg::*;
(
  input  logic                   clock_i,
  input  logic                   reset_i,
  cpu_ctrl_if.datapath           ctrl,
  input  logic [`CPU_DATA_W-1:0] data_i,
  input  logic [`CPU_DATA_W-1:0] hold_i,
  input  status_t                alu_flags_i,
  output logic [`CPU_DATA_W-1:0] acc_o,
  output logic [`CPU_DATA_W-1:0] x_o,
  output logic                   carry_o,
  output logic [`CPU_ADDR_W-1:0] address_o,
  output logic [`CPU_DATA_W-1:0] data_o
);

  logic [`CPU_DATA_W-1:0] acc;
  logic [`CPU_DATA_W-1:0] acc_next;
  logic [`CPU_DATA_W-1:0] x;
  logic [`CPU_DATA_W-1:0] x_next;
  status_t                status;
  status_t                status_next;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] pc_next;
  logic [`CPU_ADDR_W-1:0] pc_inc;
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`CPU_ADDR_W-1:0] addr_next;
  logic [`CPU_DATA_W-1:0] wdata;
  logic [`CPU_DATA_W-1:0] wdata_next;

  assign pc_inc = pc + 1'b1;

  // Later sources win
  always_comb begin
    acc_next    = acc;
    x_next      = x;
    status_next = status;
    pc_next     = pc;
    addr_next   = addr;
    wdata_next  = wdata;

    if (ctrl.load_acc_from_data) begin
      acc_next = data_i;
    end
    if (ctrl.load_acc_from_hold) begin
      acc_next = hold_i;
    end
    if (ctrl.load_x_from_data) begin
      x_next = data_i;
    end
    if (ctrl.load_x_from_acc) begin
      x_next = acc;
    end

    if (ctrl.alu_flags_to_status) begin
      status_next = alu_flags_i;
    end
    // Loads leave carry alone
    if (ctrl.data_flags_to_status) begin
      status_next[STATUS_ZERO]     = (data_i == '0);
      status_next[STATUS_NEGATIVE] = data_i[`CPU_DATA_W-1];
    end

    if (ctrl.pc_low_from_data) begin
      pc_next[`CPU_DATA_W-1:0] = data_i;
    end
    if (ctrl.pc_high_from_data) begin
      pc_next[`CPU_ADDR_W-1:`CPU_DATA_W] = data_i;
    end
    if (ctrl.pc_increment) begin
      pc_next = pc_inc;
    end

    if (ctrl.addr_from_data_zp) begin
      addr_next = {`CPU_ZERO_PAGE_HI, data_i};
    end
    if (ctrl.addr_from_pc_next) begin
      addr_next = pc_inc;
    end
    if (ctrl.addr_from_vector_hi) begin
      addr_next = `CPU_RESET_VEC_HI;
    end
    if (ctrl.addr_from_hold_zp) begin
      addr_next = {`CPU_ZERO_PAGE_HI, hold_i};
    end
    // High byte override for absolute targets
    if (ctrl.addr_high_from_data) begin
      addr_next[`CPU_ADDR_W-1:`CPU_DATA_W] = data_i;
    end

    if (ctrl.acc_to_write_data) begin
      wdata_next = acc;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      acc    <= '0;
      x      <= '0;
      status <= '0;
      addr   <= `CPU_RESET_VEC_LO;
    end else begin
      acc    <= acc_next;
      x      <= x_next;
      status <= status_next;
      addr   <= addr_next;
    end
  end

  always_ff @(posedge clock_i) begin
    pc    <= pc_next;
    wdata <= wdata_next;
  end

  assign acc_o     = acc;
  assign x_o       = x;
  assign carry_o   = status[STATUS_CARRY];
  assign address_o = addr;
  assign data_o    = wdata;

  a_single_load: assert property (
    @(posedge clock_i) disable iff (reset_i)
      !((ctrl.load_acc_from_data || ctrl.load_acc_from_hold) && ctrl.load_x_from_data)
  );

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_top
  import cpu_pkg::*;
(
  input  logic                   clock_i,
  input  logic                   reset_i,
  input  logic [`CPU_DATA_W-1:0] data_i,
  input  logic                   data_valid_i,
  output logic [`CPU_DATA_W-1:0] data_o,
  output logic [`CPU_ADDR_W-1:0] address_o,
  output logic                   bus_read_o,
  output logic                   bus_write_o
);

  logic [`CPU_DATA_W-1:0] acc;
  logic [`CPU_DATA_W-1:0] x;
  logic                   carry;
  logic [`CPU_DATA_W-1:0] hold;
  status_t                alu_flags;

  cpu_ctrl_if u_ctrl ();

  cpu_decode u_decode (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .data_i       (data_i),
    .data_valid_i (data_valid_i),
    .ctrl         (u_ctrl.decode),
    .bus_read_o   (bus_read_o),
    .bus_write_o  (bus_write_o)
  );

  cpu_alu u_alu (
    .clock_i (clock_i),
    .reset_i (reset_i),
    .ctrl    (u_ctrl.alu),
    .data_i  (data_i),
    .acc_i   (acc),
    .x_i     (x),
    .carry_i (carry),
    .hold_o  (hold),
    .flags_o (alu_flags)
  );

  cpu_datapath u_datapath (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .ctrl        (u_ctrl.datapath),
    .data_i      (data_i),
    .hold_i      (hold),
    .alu_flags_i (alu_flags),
    .acc_o       (acc),
    .x_o         (x),
    .carry_o     (carry),
    .address_o   (address_o),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

//--- tb_cpu_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_memory #(
  parameter int SEED = 1
) (
  input  logic                   clock_i,
  input  logic                   reset_i,
  input  logic                   random_wait_i,
  input  logic [`CPU_ADDR_W-1:0] address_i,
  input  logic                   bus_read_i,
  input  logic                   bus_write_i,
  input  logic [`CPU_DATA_W-1:0] data_i,
  output logic [`CPU_DATA_W-1:0] data_o,
  output logic                   data_valid_o
);

  localparam int WRITE_LOG_DEPTH = 16;

  logic [`CPU_DATA_W-1:0] mem [0:(1 << `CPU_ADDR_W)-1];
  logic [`CPU_ADDR_W-1:0] write_addr [0:WRITE_LOG_DEPTH-1];
  logic [`CPU_DATA_W-1:0] write_data [0:WRITE_LOG_DEPTH-1];
  int                     write_count;
  int                     seed;
  int                     delay;
  int                     wait_left;
  logic                   busy;

  initial begin
    seed         = SEED;
    data_o       = '0;
    data_valid_o = 1'b0;
    write_count  = 0;
    wait_left    = 0;
    busy         = 1'b0;
  end

  // Background pattern mixes both address bytes
  task automatic fill(input logic [7:0] salt);
    int i;
    for (i = 0; i < (1 << `CPU_ADDR_W); i++) begin
      mem[i] = i[15:8] ^ i[7:0] ^ salt;
    end
  endtask

  task automatic poke(input logic [`CPU_ADDR_W-1:0] addr, input logic [`CPU_DATA_W-1:0] value);
    mem[addr] = value;
  endtask

  always @(posedge clock_i) begin
    if (reset_i) begin
      data_valid_o <= 1'b0;
      busy         <= 1'b0;
      wait_left    <= 0;
      write_count  <= 0;
    end else begin
      if (bus_write_i) begin
        mem[address_i] <= data_i;
        if (write_count < WRITE_LOG_DEPTH) begin
          write_addr[write_count] <= address_i;
          write_data[write_count] <= data_i;
        end
        write_count <= write_count + 1;
      end
      if (data_valid_o) begin
        // Byte is taken at this edge, address may move
        data_valid_o <= 1'b0;
      end else if (busy) begin
        if (wait_left == 0) begin
          data_o       <= mem[address_i];
          data_valid_o <= 1'b1;
          busy         <= 1'b0;
        end else begin
          wait_left <= wait_left - 1;
        end
      end else if (bus_read_i) begin
        if (random_wait_i) begin
          delay = $unsigned($random(seed)) % 4;
        end else begin
          delay = 0;
        end
        if (delay == 0) begin
          data_o       <= mem[address_i];
          data_valid_o <= 1'b1;
        end else begin
          busy      <= 1'b1;
          wait_left <= delay - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_top
  import cpu_pkg::*;
();

  localparam int CLOCK_PERIOD = 20;
  localparam int WAIT_SEED    = 32'h09bd_78dd;
  localparam int TEST_CYCLES  = 400;
  localparam int NUM_TESTS    = 9;
  localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLOCK_PERIOD * 4;
  localparam int LOG_DEPTH    = 64;

  logic                   clock;
  logic                   reset;
  logic                   random_wait;
  logic [`CPU_DATA_W-1:0] mem_rdata;
  logic                   mem_valid;
  logic [`CPU_DATA_W-1:0] cpu_wdata;
  logic [`CPU_ADDR_W-1:0] address;
  logic                   bus_read;
  logic                   bus_write;

  logic [`CPU_ADDR_W-1:0] read_log [0:LOG_DEPTH-1];
  int                     read_count;
  int                     halt_fetches;
  logic [`CPU_ADDR_W-1:0] halt_address;
  logic [`CPU_ADDR_W-1:0] cursor;
  int                     error_count;
  int                     check_count;

  cpu_top u_cpu_top (
    .clock_i      (clock),
    .reset_i      (reset),
    .data_i       (mem_rdata),
    .data_valid_i (mem_valid),
    .data_o       (cpu_wdata),
    .address_o    (address),
    .bus_read_o   (bus_read),
    .bus_write_o  (bus_write)
  );

  tb_cpu_memory #(
    .SEED (WAIT_SEED)
  ) u_memory (
    .clock_i       (clock),
    .reset_i       (reset),
    .random_wait_i (random_wait),
    .address_i     (address),
    .bus_read_i    (bus_read),
    .bus_write_i   (bus_write),
    .data_i        (cpu_wdata),
    .data_o        (mem_rdata),
    .data_valid_o  (mem_valid)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(CLOCK_PERIOD / 2) clock = ~clock;
    end
  end

  // Every byte the core accepts
  always @(posedge clock) begin
    if (!reset && bus_read && mem_valid) begin
      if (read_count < LOG_DEPTH) begin
        read_log[read_count] = address;
      end
      read_count = read_count + 1;
      if (address == halt_address) begin
        halt_fetches = halt_fetches + 1;
      end
    end
  end

  task automatic compare_values(input logic [15:0] expected, input logic [15:0] actual,
                                input string what);
    check_count = check_count + 1;
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
      error_count = error_count + 1;
    end
  endtask

  task automatic expect_write(input int index, input logic [15:0] addr, input logic [7:0] value);
    if (index >= u_memory.write_count) begin
      $display("Write number %0d to address %h never happened", index, addr);
      error_count = error_count + 1;
    end else begin
      compare_values(addr, u_memory.write_addr[index], "write address");
      compare_values(value, u_memory.write_data[index], "write data");
    end
  endtask

  // Core stays in reset while memory is rebuilt
  task automatic enter_reset(input logic [7:0] salt, input logic [15:0] origin);
    @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    u_memory.fill(salt);
    cursor = origin;
  endtask

  task automatic emit_byte(input logic [7:0] value);
    u_memory.poke(cursor, value);
    cursor = cursor + 1'b1;
  endtask

  task automatic emit_op(input opcode_e op);
    emit_byte(op);
  endtask

  task automatic emit_op_byte(input opcode_e op, input logic [7:0] operand);
    emit_byte(op);
    emit_byte(operand);
  endtask

  task automatic emit_op_word(input opcode_e op, input logic [15:0] operand);
    emit_byte(op);
    emit_byte(operand[7:0]);
    emit_byte(operand[15:8]);
  endtask

  task automatic emit_self_jump(output logic [15:0] halt);
    halt = cursor;
    emit_op_word(OP_JMP_ABS, halt);
  endtask

  task automatic run_program(input logic [15:0] start, input logic [15:0] halt,
                             input logic stalls);
    int cycles;
    u_memory.poke(`CPU_RESET_VEC_LO, start[7:0]);
    u_memory.poke(`CPU_RESET_VEC_HI, start[15:8]);
    halt_address = halt;
    @(posedge clock);
    read_count   = 0;
    halt_fetches = 0;
    random_wait <= stalls;
    reset       <= 1'b0;
    cycles = 0;
    // The closing loop fetches its own address twice
    while (halt_fetches < 2 && cycles < TEST_CYCLES) begin
      @(negedge clock);
      cycles = cycles + 1;
    end
    if (halt_fetches < 2) begin
      $display("Program at %h did not reach its closing loop in %0d cycles", start, TEST_CYCLES);
      error_count = error_count + 1;
    end
  endtask

  task automatic verify_reset_vector();
    logic [15:0] halt;
    enter_reset(8'h11, 16'hC2A0);
    emit_self_jump(halt);
    run_program(16'hC2A0, halt, 1'b0);
    compare_values(`CPU_RESET_VEC_LO, read_log[0], "first read address");
    compare_values(`CPU_RESET_VEC_HI, read_log[1], "second read address");
    compare_values(16'hC2A0, read_log[2], "fetch from reset vector");
  endtask

  task automatic load_store_program(input logic stalls);
    logic [15:0] halt;
    enter_reset(8'h3C, 16'h0400);
    u_memory.poke(16'h0080, 8'hC3);
    emit_op_byte(OP_LDA_IMM, 8'h5A);
    emit_op_byte(OP_STA_ZP, 8'h10);
    emit_op_byte(OP_LDA_ZP, 8'h80);
    emit_op_byte(OP_STA_ZP, 8'h11);
    emit_self_jump(halt);
    run_program(16'h0400, halt, stalls);
    compare_values(2, u_memory.write_count, "load and store write count");
    expect_write(0, 16'h0010, 8'h5A);
    expect_write(1, 16'h0011, 8'hC3);
  endtask

  task automatic adc_carry_chain(input logic stalls);
    logic [15:0] halt;
    logic [8:0]  sum_first;
    logic [8:0]  sum_second;
    enter_reset(8'h5E, 16'h0600);
    emit_op_byte(OP_LDA_IMM, 8'hF0);
    emit_op_byte(OP_ADC_IMM, 8'h2F);
    emit_op_byte(OP_STA_ZP, 8'h20);
    emit_op_byte(OP_ADC_IMM, 8'hE0);
    emit_op_byte(OP_STA_ZP, 8'h21);
    emit_self_jump(halt);
    run_program(16'h0600, halt, stalls);
    // Carry starts clear, then chains
    sum_first  = {1'b0, 8'hF0} + {1'b0, 8'h2F};
    sum_second = {1'b0, sum_first[7:0]} + {1'b0, 8'hE0} + {8'h00, sum_first[8]};
    compare_values(2, u_memory.write_count, "ADC write count");
    expect_write(0, 16'h0020, sum_first[7:0]);
    expect_write(1, 16'h0021, sum_second[7:0]);
  endtask

  task automatic index_x_program(input logic stalls);
    logic [15:0] halt;
    logic [7:0]  zp_first;
    logic [7:0]  zp_second;
    logic [7:0]  zp_third;
    enter_reset(8'h92, 16'h0800);
    zp_first  = 8'h41 + 8'h03;
    zp_second = 8'h20 + 8'hF0;
    zp_third  = 8'h01 + 8'h29;
    u_memory.poke({8'h00, zp_first}, 8'h3C);
    u_memory.poke(16'h0050, 8'hF0);
    u_memory.poke({8'h00, zp_second}, 8'h77);
    // Would be read if the index carried out of page zero
    u_memory.poke({8'h01, zp_second}, 8'h88);
    u_memory.poke({8'h00, zp_third}, 8'h9E);
    emit_op_byte(OP_LDX_IMM, 8'h03);
    emit_op_byte(OP_LDA_ZPX, 8'h41);
    emit_op_byte(OP_STA_ZP, 8'h30);
    emit_op_byte(OP_LDX_ZP, 8'h50);
    emit_op_byte(OP_LDA_ZPX, 8'h20);
    emit_op_byte(OP_STA_ZP, 8'h31);
    emit_op_byte(OP_LDA_IMM, 8'h29);
    emit_op(OP_TAX);
    emit_op_byte(OP_LDA_ZPX, 8'h01);
    emit_op_byte(OP_STA_ZP, 8'h32);
    emit_self_jump(halt);
    run_program(16'h0800, halt, stalls);
    compare_values(3, u_memory.write_count, "X path write count");
    expect_write(0, 16'h0030, 8'h3C);
    expect_write(1, 16'h0031, 8'h77);
    expect_write(2, 16'h0032, 8'h9E);
  endtask

  task automatic absolute_and_jump(input logic stalls);
    logic [15:0] halt;
    enter_reset(8'hA7, 16'h0A00);
    u_memory.poke(16'h3456, 8'h6B);
    emit_op(OP_NOP);
    emit_op(OP_NOP);
    emit_op_word(OP_JMP_ABS, 16'h1F3B);
    cursor = 16'h1F3B;
    emit_op_word(OP_LDA_ABS, 16'h3456);
    emit_op_byte(OP_STA_ZP, 8'h40);
    emit_self_jump(halt);
    run_program(16'h0A00, halt, stalls);
    compare_values(1, u_memory.write_count, "absolute load write count");
    expect_write(0, 16'h0040, 8'h6B);
    compare_values(16'h0A01, read_log[3], "fetch after first NOP");
    compare_values(16'h0A02, read_log[4], "fetch after second NOP");
    compare_values(16'h1F3B, read_log[7], "fetch after JMP");
    compare_values(16'h3456, read_log[10], "absolute load address");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    random_wait  = 1'b0;
    halt_address = '0;
    cursor       = '0;
    read_count   = 0;
    halt_fetches = 0;
    error_count  = 0;
    check_count  = 0;

    verify_reset_vector();
    load_store_program(1'b0);
    adc_carry_chain(1'b0);
    index_x_program(1'b0);
    absolute_and_jump(1'b0);

    // Same programs with random wait states
    load_store_program(1'b1);
    adc_carry_chain(1'b1);
    index_x_program(1'b1);
    absolute_and_jump(1'b1);

    $display("Finished %0d checks with %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_decode.sv
cpu_alu.sv
cpu_datapath.sv
cpu_top.sv
tb_cpu_memory.sv
tb_cpu_top.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - cpu_ctrl_if.sv
  - cpu_decode.sv
  - cpu_alu.sv
  - cpu_datapath.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu_memory.sv
      - tb_cpu_top.sv
